/* verilog.f */
+incdir+.
mdu_pkg.sv
rob_pkg.sv
md_issue_queue.sv
multiplier.sv
divider.sv
mult.sv
md_unit_top.sv
tb_md_unit.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_md_unit
FILELIST ?= verilog.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_md_model.svh */
`ifndef TB_MD_MODEL_SVH
`define TB_MD_MODEL_SVH

// one step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// full 64-bit product, {hi, lo}
function automatic dword_t model_mul(input md_op_t op, input word_t a, input word_t b);
    longint sa;
    longint sb;
    if (op == MD_MULT) begin
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        return dword_t'(sa * sb);
    end
    return {32'd0, a} * {32'd0, b};
endfunction

// hi = remainder, lo = quotient
function automatic dword_t model_div(input md_op_t op, input word_t a, input word_t b);
    word_t ma;
    word_t mb;
    word_t q;
    word_t r;
    logic  neg_q;
    logic  neg_r;
    neg_r = (op == MD_DIV) && a[31];
    neg_q = (op == MD_DIV) && (a[31] ^ b[31]);
    ma = neg_r ? -a : a;
    mb = ((op == MD_DIV) && b[31]) ? -b : b;
    // zero divisor, every trial subtraction succeeds
    q = (mb == 32'd0) ? 32'hFFFF_FFFF : ma / mb;
    r = (mb == 32'd0) ? ma : ma % mb;
    return {(neg_r ? -r : r), (neg_q ? -q : q)};
endfunction

function automatic dword_t model_hilo(input md_op_t op, input word_t a, input word_t b);
    if (op == MD_MULT || op == MD_MULTU) begin
        return model_mul(op, a, b);
    end
    return model_div(op, a, b);
endfunction

`endif

/* tb_md_unit.sv */
`timescale 1ns/100ps

module tb_md_unit;
    import mdu_pkg::*;
    import rob_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int MUL_STAGES  = 3;
    localparam int WAIT_LIMIT  = 1000;

    `include "tb_md_model.svh"

    logic      clk = 1'b0;
    logic      reset;
    logic      flush;
    logic      issue_valid;
    md_op_t    issue_op;
    word_t     issue_a;
    word_t     issue_b;
    rob_addr_t issue_dst;
    exc_t      issue_exception;
    logic      issue_ready;
    logic      commit_valid;
    word_t     commit_hi;
    word_t     commit_lo;
    rob_addr_t commit_rob_addr;
    exc_t      commit_exception;

    // scoreboard, oldest accepted operation first
    dword_t    sb_hilo [$];
    rob_addr_t sb_dst [$];
    exc_t      sb_exc [$];
    int        sb_acc [$];
    int        sb_lat [$];

    // scoreboard head as the assertions see it
    int        sb_count = 0;
    dword_t    exp_hilo;
    rob_addr_t exp_dst;
    exc_t      exp_exc;
    int        exp_acc;
    int        exp_lat;

    md_op_t      all_ops [4] = '{MD_MULT, MD_MULTU, MD_DIV, MD_DIVU};
    logic [31:0] rng_state = 32'h66216345;
    int          cycle_cnt = 0;
    int          err_count = 0;
    int          timeout_count = 0;
    int          accept_count = 0;
    int          commit_count = 0;
    int          dropped_count = 0;
    logic        commit_prev = 1'b0;
    logic        saw_full = 1'b0;

    md_unit_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .MUL_STAGES(MUL_STAGES)
    ) u_md_unit_top (
        .clk, .reset, .flush,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_dst, .issue_exception,
        .issue_ready,
        .commit_valid, .commit_hi, .commit_lo, .commit_rob_addr, .commit_exception
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic void log_error(input string msg);
        err_count++;
        $display("[ERROR] %0t %s", $time, msg);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic md_op_t rand_op();
        logic [31:0] r;
        r = next_rand();
        return all_ops[r[1:0]];
    endfunction

    function automatic word_t edge_word(input int i);
        case (i)
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'h8000_0000;
            3: return 32'hFFFF_FFFF;
            default: return 32'h7FFF_FFFF;
        endcase
    endfunction

    function automatic void refresh_head();
        sb_count = sb_hilo.size();
        if (sb_count > 0) begin
            exp_hilo = sb_hilo[0];
            exp_dst  = sb_dst[0];
            exp_exc  = sb_exc[0];
            exp_acc  = sb_acc[0];
            exp_lat  = sb_lat[0];
        end
    endfunction

    // flush or reset drops everything outstanding
    function automatic void clear_scoreboard();
        dropped_count += sb_hilo.size();
        sb_hilo.delete();
        sb_dst.delete();
        sb_exc.delete();
        sb_acc.delete();
        sb_lat.delete();
        refresh_head();
    endfunction

    // retire the head one half cycle after its commit was sampled
    always @(negedge clk) begin
        if (commit_prev) begin
            commit_count++;
        end
        if (commit_prev && sb_count > 0) begin
            void'(sb_hilo.pop_front());
            void'(sb_dst.pop_front());
            void'(sb_exc.pop_front());
            void'(sb_acc.pop_front());
            void'(sb_lat.pop_front());
            refresh_head();
        end
        commit_prev = commit_valid;
    end

    a_commit_expected: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> sb_count > 0)
        else log_error("commit with no operation outstanding");

    a_commit_value: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> {commit_hi, commit_lo} == exp_hilo)
        else log_error($sformatf("hilo %h_%h, expected %h", commit_hi, commit_lo, exp_hilo));

    a_commit_tag: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> commit_rob_addr == exp_dst && commit_exception == exp_exc)
        else log_error($sformatf("tag %0d/%h, expected %0d/%h",
            commit_rob_addr, commit_exception, exp_dst, exp_exc));

    a_latency: assert property (@(posedge clk) disable iff (reset)
        commit_valid && exp_lat != 0 |-> cycle_cnt - exp_acc == exp_lat)
        else log_error($sformatf("latency %0d, expected %0d", cycle_cnt - exp_acc, exp_lat));

    a_reset_ready: assert property (@(posedge clk) reset |-> !issue_ready)
        else log_error("issue_ready high during reset");

    a_reset_commit: assert property (@(posedge clk) reset && cycle_cnt > 0 |-> !commit_valid)
        else log_error("commit_valid high during reset");

    // called on a falling edge, returns on a falling edge
    task automatic send_op(input md_op_t op, input word_t a, input word_t b, input logic timed);
        int waited;
        int lat;
        waited = 0;
        lat = (op == MD_MULT || op == MD_MULTU) ? MUL_STAGES + 3 : DIV_CYCLES + 4;
        issue_valid     = 1'b1;
        issue_op        = op;
        issue_a         = a;
        issue_b         = b;
        issue_dst       = rob_addr_t'(next_rand());
        issue_exception = exc_t'(next_rand());
        #1;
        while (!issue_ready && waited < WAIT_LIMIT) begin
            saw_full = 1'b1;
            @(negedge clk);
            #1;
            waited++;
        end
        if (!issue_ready) begin
            $display("timeout: issue_ready stayed low, operation not accepted");
            timeout_count++;
        end else begin
            sb_hilo.push_back(model_hilo(op, a, b));
            sb_dst.push_back(issue_dst);
            sb_exc.push_back(issue_exception);
            sb_acc.push_back(cycle_cnt);
            sb_lat.push_back(timed ? lat : 0);
            accept_count++;
            refresh_head();
        end
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (sb_count > 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (sb_count > 0) begin
            $display("timeout: %0d operations never committed", sb_count);
            timeout_count++;
            clear_scoreboard();
        end
    endtask

    // idle unit and empty queue, so the latency is checked too
    task automatic run_single(input md_op_t op, input word_t a, input word_t b);
        wait_idle();
        send_op(op, a, b, 1'b1);
    endtask

    initial begin
        logic [31:0] sh;
        reset           = 1'b1;
        flush           = 1'b0;
        issue_valid     = 1'b0;
        issue_op        = MD_MULT;
        issue_a         = '0;
        issue_b         = '0;
        issue_dst       = '0;
        issue_exception = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // every operation on every pair of edge operands
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    run_single(all_ops[k], edge_word(i), edge_word(j));
                end
            end
        end

        // random operands, divisors of varied size
        for (int n = 0; n < 40; n++) begin
            sh = next_rand();
            run_single(rand_op(), next_rand(), next_rand() >> sh[4:0]);
        end

        // mixed bursts, commits keep issue order
        for (int k = 0; k < 4; k++) begin
            for (int n = 0; n < 6; n++) begin
                send_op(rand_op(), next_rand(), next_rand(), 1'b0);
            end
            wait_idle();
        end

        // burst past the queue depth
        saw_full = 1'b0;
        for (int n = 0; n < QUEUE_DEPTH + 4; n++) begin
            send_op(MD_MULT, next_rand(), next_rand(), 1'b0);
        end
        wait_idle();
        a_backpressure: assert (saw_full) else begin
            $display("issue_ready never went low during a burst past the queue depth");
            err_count++;
        end

        // flush with a divide running and operations queued behind it
        send_op(MD_DIV, next_rand(), 32'd3, 1'b0);
        for (int n = 0; n < 3; n++) begin
            send_op(rand_op(), next_rand(), next_rand(), 1'b0);
        end
        repeat (6) @(negedge clk);
        flush = 1'b1;
        #1;
        clear_scoreboard();
        @(negedge clk);
        flush = 1'b0;
        repeat (DIV_CYCLES + 10) @(negedge clk);
        run_single(MD_MULTU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);

        // reset in the middle of a divide
        wait_idle();
        send_op(MD_DIVU, next_rand(), 32'd7, 1'b0);
        send_op(MD_MULT, next_rand(), next_rand(), 1'b0);
        repeat (4) @(negedge clk);
        reset = 1'b1;
        #1;
        clear_scoreboard();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (DIV_CYCLES + 10) @(negedge clk);
        run_single(MD_DIV, 32'h8000_0000, 32'hFFFF_FFFF);
        wait_idle();

        a_no_loss: assert (accept_count == commit_count + dropped_count) else begin
            $display("accepted %0d operations, but %0d committed and %0d dropped",
                accept_count, commit_count, dropped_count);
            err_count++;
        end

        $display("errors: %0d  timeouts: %0d  accepted: %0d  committed: %0d  dropped: %0d",
            err_count, timeout_count, accept_count, commit_count, dropped_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* md_unit_top.sv */
`timescale 1ns/100ps

module md_unit_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MUL_STAGES  = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               issue_valid,
    input  mdu_pkg::md_op_t    issue_op,
    input  mdu_pkg::word_t     issue_a,
    input  mdu_pkg::word_t     issue_b,
    input  rob_pkg::rob_addr_t issue_dst,
    input  rob_pkg::exc_t      issue_exception,
    output logic               issue_ready,
    output logic               commit_valid,
    output mdu_pkg::word_t     commit_hi,
    output mdu_pkg::word_t     commit_lo,
    output rob_pkg::rob_addr_t commit_rob_addr,
    output rob_pkg::exc_t      commit_exception
);
    import mdu_pkg::*;
    import rob_pkg::*;

    // queue head
    logic      q_valid;
    logic      q_pop;
    md_op_t    q_op;
    word_t     q_a;
    word_t     q_b;
    rob_addr_t q_dst;
    exc_t      q_exc;

    // arithmetic blocks
    logic   mul_start;
    logic   mul_signed;
    word_t  mul_a;
    word_t  mul_b;
    dword_t mul_hilo;
    logic   mul_done;
    logic   div_start;
    logic   div_signed;
    word_t  div_a;
    word_t  div_b;
    dword_t div_hilo;
    logic   div_done;

    md_issue_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk, .reset, .flush,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_dst, .issue_exception,
        .issue_ready,
        .q_pop, .q_valid, .q_op, .q_a, .q_b, .q_dst, .q_exc
    );

    mult u_ctrl (
        .clk, .reset, .flush,
        .q_valid, .q_op, .q_a, .q_b, .q_dst, .q_exc, .q_pop,
        .mul_start, .mul_signed, .mul_a, .mul_b, .mul_hilo, .mul_done,
        .div_start, .div_signed, .div_a, .div_b, .div_hilo, .div_done,
        .commit_valid, .commit_hi, .commit_lo, .commit_rob_addr, .commit_exception
    );

    multiplier #(
        .MUL_STAGES(MUL_STAGES)
    ) u_mul (
        .clk, .reset, .flush,
        .mul_start, .mul_signed, .mul_a, .mul_b, .mul_hilo, .mul_done
    );

    divider u_div (
        .clk, .reset, .flush,
        .div_start, .div_signed, .div_a, .div_b, .div_hilo, .div_done
    );

endmodule

/* mult.sv */
`timescale 1ns/100ps

module mult (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               q_valid,
    input  mdu_pkg::md_op_t    q_op,
    input  mdu_pkg::word_t     q_a,
    input  mdu_pkg::word_t     q_b,
    input  rob_pkg::rob_addr_t q_dst,
    input  rob_pkg::exc_t      q_exc,
    output logic               q_pop,
    output logic               mul_start,
    output logic               mul_signed,
    output mdu_pkg::word_t     mul_a,
    output mdu_pkg::word_t     mul_b,
    input  mdu_pkg::dword_t    mul_hilo,
    input  logic               mul_done,
    output logic               div_start,
    output logic               div_signed,
    output mdu_pkg::word_t     div_a,
    output mdu_pkg::word_t     div_b,
    input  mdu_pkg::dword_t    div_hilo,
    input  logic               div_done,
    output logic               commit_valid,
    output mdu_pkg::word_t     commit_hi,
    output mdu_pkg::word_t     commit_lo,
    output rob_pkg::rob_addr_t commit_rob_addr,
    output rob_pkg::exc_t      commit_exception
);
    import mdu_pkg::*;
    import rob_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_WAIT
    } state_t;

    state_t    state;
    md_op_t    op_r;
    word_t     a_r;
    word_t     b_r;
    rob_addr_t dst_r;
    exc_t      exc_r;
    logic      is_mul;
    logic      unit_done;
    dword_t    unit_hilo;

    // take the head only when nothing is in flight
    assign q_pop = (state == S_IDLE) && q_valid;

    assign is_mul    = (op_r == MD_MULT) || (op_r == MD_MULTU);
    assign unit_done = is_mul ? mul_done : div_done;
    assign unit_hilo = is_mul ? mul_hilo : div_hilo;

    assign mul_start  = (state == S_START) && is_mul;
    assign mul_signed = (op_r == MD_MULT);
    assign mul_a      = a_r;
    assign mul_b      = b_r;

    assign div_start  = (state == S_START) && !is_mul;
    assign div_signed = (op_r == MD_DIV);
    assign div_a      = a_r;
    assign div_b      = b_r;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state        <= S_IDLE;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (q_pop) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (unit_done) begin
                        commit_valid <= 1'b1;
                        state        <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // operation and tag held until the next pop
    always_ff @(posedge clk) begin
        if (q_pop) begin
            op_r  <= q_op;
            a_r   <= q_a;
            b_r   <= q_b;
            dst_r <= q_dst;
            exc_r <= q_exc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WAIT && unit_done) begin
            {commit_hi, commit_lo} <= unit_hilo;
        end
    end

    assign commit_rob_addr  = dst_r;
    assign commit_exception = exc_r;

endmodule

/* divider.sv */
`timescale 1ns/100ps

module divider (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            div_start,
    input  logic            div_signed,
    input  mdu_pkg::word_t  div_a,
    input  mdu_pkg::word_t  div_b,
    output mdu_pkg::dword_t div_hilo,
    output logic            div_done
);
    import mdu_pkg::*;

    localparam int CNT_W = $clog2(DIV_CYCLES);

    logic             busy;
    logic [CNT_W-1:0] count;
    word_t            rem;
    word_t            quo;
    word_t            divisor;
    logic             neg_q;
    logic             neg_r;
    word_t            abs_a;
    word_t            abs_b;
    dword_t           first_step;
    dword_t           next_step;

    // one restoring step, returns {remainder, quotient}
    function automatic dword_t restore_step(input word_t r, input word_t q, input word_t d);
        logic [33:0] trial;
        trial = {1'b0, r, q[31]} - {2'b00, d};
        if (trial[33]) begin
            return {r[30:0], q[31], q[30:0], 1'b0};
        end
        return {trial[31:0], q[30:0], 1'b1};
    endfunction

    assign abs_a = (div_signed && div_a[31]) ? -div_a : div_a;
    assign abs_b = (div_signed && div_b[31]) ? -div_b : div_b;

    // first step is folded into the load cycle
    assign first_step = restore_step('0, abs_a, abs_b);
    assign next_step  = restore_step(rem, quo, divisor);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy     <= 1'b0;
            count    <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= busy && (count == '0);
            if (div_start) begin
                busy  <= 1'b1;
                count <= CNT_W'(DIV_CYCLES - 1);
            end else if (busy) begin
                if (count == '0) begin
                    busy <= 1'b0;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            {rem, quo} <= first_step;
            divisor    <= abs_b;
            neg_q      <= div_signed && (div_a[31] ^ div_b[31]);
            neg_r      <= div_signed && div_a[31];
        end else if (busy) begin
            if (count != '0) begin
                {rem, quo} <= next_step;
            end else begin
                // sign fix, remainder follows the dividend
                div_hilo <= {(neg_r ? -rem : rem), (neg_q ? -quo : quo)};
            end
        end
    end

endmodule

/* multiplier.sv */
`timescale 1ns/100ps

module multiplier #(
    parameter int MUL_STAGES = 3
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            mul_start,
    input  logic            mul_signed,
    input  mdu_pkg::word_t  mul_a,
    input  mdu_pkg::word_t  mul_b,
    output mdu_pkg::dword_t mul_hilo,
    output logic            mul_done
);
    import mdu_pkg::*;

    logic [32:0]        a_ext;
    logic [32:0]        b_ext;
    logic signed [65:0] product;

    dword_t                prod_pipe [MUL_STAGES];
    logic [MUL_STAGES-1:0] valid_pipe;

    // 33-bit operands so one signed multiply covers both flavours
    assign a_ext   = {mul_signed & mul_a[31], mul_a};
    assign b_ext   = {mul_signed & mul_b[31], mul_b};
    assign product = $signed(a_ext) * $signed(b_ext);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= mul_start;
            for (int i = 1; i < MUL_STAGES; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        prod_pipe[0] <= product[63:0];
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_pipe[i] <= prod_pipe[i-1];
        end
    end

    assign mul_hilo = prod_pipe[MUL_STAGES-1];
    assign mul_done = valid_pipe[MUL_STAGES-1];

endmodule

/* md_issue_queue.sv */
`timescale 1ns/100ps

module md_issue_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              issue_valid,
    input  mdu_pkg::md_op_t   issue_op,
    input  mdu_pkg::word_t    issue_a,
    input  mdu_pkg::word_t    issue_b,
    input  rob_pkg::rob_addr_t issue_dst,
    input  rob_pkg::exc_t     issue_exception,
    output logic              issue_ready,
    input  logic              q_pop,
    output logic              q_valid,
    output mdu_pkg::md_op_t   q_op,
    output mdu_pkg::word_t    q_a,
    output mdu_pkg::word_t    q_b,
    output rob_pkg::rob_addr_t q_dst,
    output rob_pkg::exc_t     q_exc
);
    import mdu_pkg::*;
    import rob_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    md_op_t    op_mem  [QUEUE_DEPTH];
    word_t     a_mem   [QUEUE_DEPTH];
    word_t     b_mem   [QUEUE_DEPTH];
    rob_addr_t dst_mem [QUEUE_DEPTH];
    exc_t      exc_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // no accept while full, in reset or in the flush cycle
    assign issue_ready = (count != CNT_W'(QUEUE_DEPTH)) && !reset && !flush;
    assign push        = issue_valid && issue_ready;
    assign pop         = q_pop && q_valid;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]  <= issue_op;
            a_mem[wr_ptr]   <= issue_a;
            b_mem[wr_ptr]   <= issue_b;
            dst_mem[wr_ptr] <= issue_dst;
            exc_mem[wr_ptr] <= issue_exception;
        end
    end

    // head straight from storage
    assign q_valid = (count != '0);
    assign q_op    = op_mem[rd_ptr];
    assign q_a     = a_mem[rd_ptr];
    assign q_b     = b_mem[rd_ptr];
    assign q_dst   = dst_mem[rd_ptr];
    assign q_exc   = exc_mem[rd_ptr];

endmodule

/* rob_pkg.sv */
package rob_pkg;

    // reorder buffer index
    localparam int ROB_ADDR_WIDTH = 6;

    typedef logic [ROB_ADDR_WIDTH-1:0] rob_addr_t;

    // exception code, passed from issue to commit untouched
    typedef logic [4:0] exc_t;

endpackage

/* mdu_pkg.sv */
package mdu_pkg;

    // operand and result words
    typedef logic [31:0] word_t;

    // {hi, lo} pair as written to HI/LO
    typedef logic [63:0] dword_t;

    // HI/LO operations handled by this unit
    typedef enum logic [1:0] {
        MD_MULT  = 2'd0,
        MD_MULTU = 2'd1,
        MD_DIV   = 2'd2,
        MD_DIVU  = 2'd3
    } md_op_t;

    // restoring divider, one quotient bit per cycle
    localparam int DIV_CYCLES = 32;

endpackage
